// ==== hw/xport_params.svh ====
// ----------------------------------------------------------------------
// Width and depth defines for the CHDR transport adapter
// ----------------------------------------------------------------------
`ifndef XPORT_PARAMS_SVH
`define XPORT_PARAMS_SVH

// Stream data width in bits
`define XPORT_CHDR_W 64

// DMA engine ID width, carried on tuser
`define XPORT_DMA_ID_W 8

// Log2 of the return-route table depth
`define XPORT_RT_TBL_SIZE 4

`endif

// ==== hw/chdr_pkg.sv ====
// ----------------------------------------------------------------------
// CHDR header field types and the packet-type encoding
// ----------------------------------------------------------------------
`include "xport_params.svh"

package chdr_pkg;

  // One stream word
  typedef logic [`XPORT_CHDR_W-1:0] chdr_word_t;

  // Endpoint ID
  typedef logic [15:0] epid_t;

  // Header field positions
  localparam int CHDR_EPID_LSB  = 0;
  localparam int CHDR_PKT_TYPE_LSB = 53;

  // Packet type, header bits 55..53
  typedef enum logic [2:0] {
    PKT_MGMT    = 3'd0,
    PKT_STRS    = 3'd1,
    PKT_STRC    = 3'd2,
    PKT_CTRL    = 3'd4,
    PKT_DATA    = 3'd6,
    PKT_DATA_TS = 3'd7
  } chdr_pkt_type_t;

endpackage

// ==== hw/xport_pkg.sv ====
// ----------------------------------------------------------------------
// Adapter-internal types: DMA ID, table index and FSM states
// ----------------------------------------------------------------------
`include "xport_params.svh"

package xport_pkg;

  // DMA engine ID on tuser
  typedef logic [`XPORT_DMA_ID_W-1:0] dma_id_t;

  // Route table slot index
  typedef logic [`XPORT_RT_TBL_SIZE-1:0] rt_index_t;

  // DMA-to-network FSM
  typedef enum logic [1:0] {
    ING_HDR,       // waiting for a header
    ING_FWD,       // forwarding packet body
    ING_ADV_HDR,   // advertise seen, next word holds the EPID
    ING_ADV_BODY   // consuming the rest of an advertise
  } ing_state_t;

  // Network-to-DMA FSM
  typedef enum logic [1:0] {
    EGR_HDR,
    EGR_FWD,
    EGR_DROP
  } egr_state_t;

endpackage

// ==== hw/xport_route_table.sv ====
// ----------------------------------------------------------------------
// Return-route table: valid bit plus DMA ID per EPID slot
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "xport_params.svh"

module xport_route_table import chdr_pkg::*, xport_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Write port from the advertise path
  input  logic      rt_wr,
  input  rt_index_t rt_wr_index,
  input  dma_id_t   rt_wr_id,
  // Lookup port for the network-to-DMA path
  input  epid_t     rd_epid,
  output logic      rt_hit,
  output dma_id_t   rt_id
);

  localparam int RT_DEPTH = 1 << `XPORT_RT_TBL_SIZE;

  logic [RT_DEPTH-1:0] entry_valid;
  dma_id_t             entry_id [RT_DEPTH];
  rt_index_t           rd_index;

  // Low EPID bits select the slot
  assign rd_index = rd_epid[`XPORT_RT_TBL_SIZE-1:0];

  // Valid bits are cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
    end else if (rt_wr) begin
      entry_valid[rt_wr_index] <= 1'b1;
    end
  end

  // Stored IDs
  always_ff @(posedge clk) begin
    if (rt_wr) begin
      entry_id[rt_wr_index] <= rt_wr_id;
    end
  end

  // Combinational lookup
  assign rt_hit = entry_valid[rd_index];
  assign rt_id  = entry_id[rd_index];

endmodule

// ==== hw/xport_adapter_ctrl.sv ====
// ----------------------------------------------------------------------
// Per-packet decision FSMs for both directions
// Route table writes from advertise packets, dropped-packet counter
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module xport_adapter_ctrl import chdr_pkg::*, xport_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  // DMA-to-network side
  input  logic           ing_valid,
  input  logic           ing_last,
  input  epid_t          ing_epid,
  input  chdr_pkt_type_t ing_type,
  input  logic           ing_out_free,
  output logic           ing_accept,
  output logic           ing_forward,
  input  rt_index_t      ing_data_low,
  input  dma_id_t        dma_tuser,
  // Route table write
  output logic           rt_wr,
  output rt_index_t      rt_wr_index,
  output dma_id_t        rt_wr_id,
  // Network-to-DMA side
  input  logic           egr_valid,
  input  logic           egr_last,
  input  logic           egr_out_free,
  input  logic           rt_hit,
  output logic           egr_accept,
  output logic           egr_forward,
  output logic           egr_first,
  output logic [15:0]    drop_count
);

  ing_state_t ing_state;
  egr_state_t egr_state;
  logic       ing_is_adv;
  logic       ing_consume;

  // ----------------------------------------------------------------------
  // DMA-to-network
  // ----------------------------------------------------------------------
  // Management packet to endpoint 0
  assign ing_is_adv = (ing_type == PKT_MGMT) && (ing_epid == '0);

  // Words of an advertise are swallowed
  assign ing_consume = (ing_state == ING_ADV_HDR) || (ing_state == ING_ADV_BODY) ||
                       ((ing_state == ING_HDR) && ing_is_adv);

  assign ing_accept  = ing_valid && (ing_consume || ing_out_free);
  assign ing_forward = ing_accept && !ing_consume;

  // Second advertise word carries the source EPID
  assign rt_wr       = ing_accept && (ing_state == ING_ADV_HDR);
  assign rt_wr_index = ing_data_low;
  assign rt_wr_id    = dma_tuser;

  always_ff @(posedge clk) begin
    if (rst) begin
      ing_state <= ING_HDR;
    end else if (ing_accept) begin
      if (ing_last) begin
        ing_state <= ING_HDR;
      end else begin
        case (ing_state)
          ING_HDR:     ing_state <= ing_is_adv ? ING_ADV_HDR : ING_FWD;
          ING_ADV_HDR: ing_state <= ING_ADV_BODY;
          default:     ing_state <= ing_state;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Network-to-DMA
  // ----------------------------------------------------------------------
  assign egr_first   = (egr_state == EGR_HDR);
  // Drop path never waits on the output
  assign egr_accept  = egr_valid && ((egr_state == EGR_DROP) ||
                       (egr_first && !rt_hit) || egr_out_free);
  assign egr_forward = egr_accept && ((egr_state == EGR_FWD) || (egr_first && rt_hit));

  always_ff @(posedge clk) begin
    if (rst) begin
      egr_state  <= EGR_HDR;
      drop_count <= '0;
    end else if (egr_accept) begin
      if (egr_first && !rt_hit && (drop_count != 16'hffff)) begin
        drop_count <= drop_count + 16'd1;   // once per missed header, saturating
      end
      if (egr_last) begin
        egr_state <= EGR_HDR;
      end else if (egr_first) begin
        egr_state <= rt_hit ? EGR_FWD : EGR_DROP;
      end
    end
  end

endmodule

// ==== hw/xport_dma_ingress.sv ====
// ----------------------------------------------------------------------
// DMA-to-network output register with header field extraction
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module xport_dma_ingress import chdr_pkg::*, xport_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  // Stream from the DMA engines
  input  chdr_word_t     s_dma_tdata,
  input  logic           s_dma_tlast,
  input  logic           s_dma_tvalid,
  output logic           s_dma_tready,
  // Stream to the network
  output chdr_word_t     m_chdr_tdata,
  output logic           m_chdr_tlast,
  output logic           m_chdr_tvalid,
  input  logic           m_chdr_tready,
  // Controller interface
  output epid_t          ing_epid,
  output chdr_pkt_type_t ing_type,
  output rt_index_t      ing_data_low,
  output logic           ing_out_free,
  input  logic           ing_accept,
  input  logic           ing_forward
);

  // Header fields from the live input word
  assign ing_epid     = s_dma_tdata[CHDR_EPID_LSB +: 16];
  assign ing_type     = chdr_pkt_type_t'(s_dma_tdata[CHDR_PKT_TYPE_LSB +: 3]);
  assign ing_data_low = s_dma_tdata[$bits(rt_index_t)-1:0];

  // Register empty or draining this cycle
  assign ing_out_free = !m_chdr_tvalid || m_chdr_tready;
  assign s_dma_tready = ing_accept && s_dma_tvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_chdr_tvalid <= 1'b0;
    end else if (ing_forward) begin
      m_chdr_tvalid <= 1'b1;
    end else if (m_chdr_tready) begin
      m_chdr_tvalid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (ing_forward) begin
      m_chdr_tdata <= s_dma_tdata;
      m_chdr_tlast <= s_dma_tlast;
    end
  end

endmodule

// ==== hw/xport_chdr_egress.sv ====
// ----------------------------------------------------------------------
// Network-to-DMA output register
// Destination DMA ID is captured on the header and held to tlast
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module xport_chdr_egress import chdr_pkg::*, xport_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Stream from the network
  input  chdr_word_t s_chdr_tdata,
  input  logic       s_chdr_tlast,
  input  logic       s_chdr_tvalid,
  output logic       s_chdr_tready,
  // Stream to the DMA engines
  output chdr_word_t m_dma_tdata,
  output dma_id_t    m_dma_tuser,
  output logic       m_dma_tlast,
  output logic       m_dma_tvalid,
  input  logic       m_dma_tready,
  // Controller and route table
  output epid_t      egr_epid,
  output logic       egr_out_free,
  input  logic       egr_accept,
  input  logic       egr_forward,
  input  logic       egr_first,
  input  dma_id_t    rt_id
);

  // Destination EPID for the table lookup
  assign egr_epid = s_chdr_tdata[CHDR_EPID_LSB +: 16];

  // Free when empty or being read this cycle
  assign egr_out_free  = !m_dma_tvalid || m_dma_tready;
  assign s_chdr_tready = egr_accept && s_chdr_tvalid;

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      m_dma_tvalid <= 1'b0;
    end else if (egr_forward) begin
      m_dma_tvalid <= 1'b1;
    end else if (m_dma_tready) begin
      m_dma_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (egr_forward) begin
      m_dma_tdata <= s_chdr_tdata;
      m_dma_tlast <= s_chdr_tlast;
    end
  end

  // Table lookup taken only on the header word
  // A rewrite of the entry mid-packet leaves tuser untouched
  always_ff @(posedge clk) begin
    if (egr_forward && egr_first) begin
      m_dma_tuser <= rt_id;
    end
  end

endmodule

// ==== hw/liberio_chdr64_adapter.sv ====
// ----------------------------------------------------------------------
// CHDR64 transport adapter top
// Connects the decision FSMs, both output stages and the route table
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module liberio_chdr64_adapter import chdr_pkg::*, xport_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // DMA side
  input  chdr_word_t  s_dma_tdata,
  input  dma_id_t     s_dma_tuser,
  input  logic        s_dma_tlast,
  input  logic        s_dma_tvalid,
  output logic        s_dma_tready,
  output chdr_word_t  m_dma_tdata,
  output dma_id_t     m_dma_tuser,
  output logic        m_dma_tlast,
  output logic        m_dma_tvalid,
  input  logic        m_dma_tready,
  // Network side
  input  chdr_word_t  s_chdr_tdata,
  input  logic        s_chdr_tlast,
  input  logic        s_chdr_tvalid,
  output logic        s_chdr_tready,
  output chdr_word_t  m_chdr_tdata,
  output logic        m_chdr_tlast,
  output logic        m_chdr_tvalid,
  input  logic        m_chdr_tready,
  // Packets dropped on a route miss
  output logic [15:0] drop_count
);

  epid_t          ing_epid;
  chdr_pkt_type_t ing_type;
  rt_index_t      ing_data_low;
  logic           ing_out_free;
  logic           ing_accept;
  logic           ing_forward;
  logic           rt_wr;
  rt_index_t      rt_wr_index;
  dma_id_t        rt_wr_id;
  epid_t          egr_epid;
  logic           egr_out_free;
  logic           egr_accept;
  logic           egr_forward;
  logic           egr_first;
  logic           rt_hit;
  dma_id_t        rt_id;

  xport_adapter_ctrl i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .ing_valid    (s_dma_tvalid),
    .ing_last     (s_dma_tlast),
    .ing_epid     (ing_epid),
    .ing_type     (ing_type),
    .ing_out_free (ing_out_free),
    .ing_accept   (ing_accept),
    .ing_forward  (ing_forward),
    .ing_data_low (ing_data_low),
    .dma_tuser    (s_dma_tuser),
    .rt_wr        (rt_wr),
    .rt_wr_index  (rt_wr_index),
    .rt_wr_id     (rt_wr_id),
    .egr_valid    (s_chdr_tvalid),
    .egr_last     (s_chdr_tlast),
    .egr_out_free (egr_out_free),
    .rt_hit       (rt_hit),
    .egr_accept   (egr_accept),
    .egr_forward  (egr_forward),
    .egr_first    (egr_first),
    .drop_count   (drop_count)
  );

  xport_dma_ingress i_dma_ingress (
    .clk           (clk),
    .rst           (rst),
    .s_dma_tdata   (s_dma_tdata),
    .s_dma_tlast   (s_dma_tlast),
    .s_dma_tvalid  (s_dma_tvalid),
    .s_dma_tready  (s_dma_tready),
    .m_chdr_tdata  (m_chdr_tdata),
    .m_chdr_tlast  (m_chdr_tlast),
    .m_chdr_tvalid (m_chdr_tvalid),
    .m_chdr_tready (m_chdr_tready),
    .ing_epid      (ing_epid),
    .ing_type      (ing_type),
    .ing_data_low  (ing_data_low),
    .ing_out_free  (ing_out_free),
    .ing_accept    (ing_accept),
    .ing_forward   (ing_forward)
  );

  xport_chdr_egress i_chdr_egress (
    .clk           (clk),
    .rst           (rst),
    .s_chdr_tdata  (s_chdr_tdata),
    .s_chdr_tlast  (s_chdr_tlast),
    .s_chdr_tvalid (s_chdr_tvalid),
    .s_chdr_tready (s_chdr_tready),
    .m_dma_tdata   (m_dma_tdata),
    .m_dma_tuser   (m_dma_tuser),
    .m_dma_tlast   (m_dma_tlast),
    .m_dma_tvalid  (m_dma_tvalid),
    .m_dma_tready  (m_dma_tready),
    .egr_epid      (egr_epid),
    .egr_out_free  (egr_out_free),
    .egr_accept    (egr_accept),
    .egr_forward   (egr_forward),
    .egr_first     (egr_first),
    .rt_id         (rt_id)
  );

  xport_route_table i_route_table (
    .clk         (clk),
    .rst         (rst),
    .rt_wr       (rt_wr),
    .rt_wr_index (rt_wr_index),
    .rt_wr_id    (rt_wr_id),
    .rd_epid     (egr_epid),
    .rt_hit      (rt_hit),
    .rt_id       (rt_id)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// ----------------------------------------------------------------------
// Testbench clock source, 40 ns period
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  // Half of the 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

// ==== dv/xport_adapter_properties.sv ====
// ----------------------------------------------------------------------
// Concurrent assertions on the adapter output streams
// Bound to liberio_chdr64_adapter
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module xport_adapter_properties import chdr_pkg::*, xport_pkg::*; (
  input logic       clk,
  input logic       rst,
  input chdr_word_t m_chdr_tdata,
  input logic       m_chdr_tlast,
  input logic       m_chdr_tvalid,
  input logic       m_chdr_tready,
  input chdr_word_t m_dma_tdata,
  input dma_id_t    m_dma_tuser,
  input logic       m_dma_tlast,
  input logic       m_dma_tvalid,
  input logic       m_dma_tready
);

  int      fail_count = 0;
  logic    in_pkt;
  dma_id_t pkt_user;

  // Tracks the tuser of the packet now on m_dma
  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (m_dma_tvalid && m_dma_tready) begin
      in_pkt   <= !m_dma_tlast;
      pkt_user <= m_dma_tuser;
    end
  end

  // ----------------------------------------------------------------------
  // Stall behavior on both outputs
  // ----------------------------------------------------------------------
  chdr_hold: assert property (@(posedge clk) disable iff (rst)
    m_chdr_tvalid && !m_chdr_tready |=>
      m_chdr_tvalid && $stable(m_chdr_tdata) && $stable(m_chdr_tlast))
    else begin
      $error("m_chdr word changed or dropped while stalled");
      fail_count++;
    end

  dma_hold: assert property (@(posedge clk) disable iff (rst)
    m_dma_tvalid && !m_dma_tready |=>
      m_dma_tvalid && $stable(m_dma_tdata) && $stable(m_dma_tlast) && $stable(m_dma_tuser))
    else begin
      $error("m_dma word changed or dropped while stalled");
      fail_count++;
    end

  // Destination ID fixed from header to tlast
  dma_user_const: assert property (@(posedge clk) disable iff (rst)
    in_pkt && m_dma_tvalid |-> m_dma_tuser == pkt_user)
    else begin
      $error("m_dma_tuser changed inside a packet");
      fail_count++;
    end

endmodule

bind liberio_chdr64_adapter xport_adapter_properties i_props (
  .clk           (clk),
  .rst           (rst),
  .m_chdr_tdata  (m_chdr_tdata),
  .m_chdr_tlast  (m_chdr_tlast),
  .m_chdr_tvalid (m_chdr_tvalid),
  .m_chdr_tready (m_chdr_tready),
  .m_dma_tdata   (m_dma_tdata),
  .m_dma_tuser   (m_dma_tuser),
  .m_dma_tlast   (m_dma_tlast),
  .m_dma_tvalid  (m_dma_tvalid),
  .m_dma_tready  (m_dma_tready)
);

// ==== dv/tb_liberio_adapter.sv ====
// ----------------------------------------------------------------------
// Directed tests for the CHDR64 transport adapter
// Scoreboard queues, route table model, xorshift stimulus, timeout
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "xport_params.svh"

module tb_liberio_adapter import chdr_pkg::*, xport_pkg::*; ();

  localparam int IDX_W          = `XPORT_RT_TBL_SIZE;
  localparam int TBL_DEPTH      = 1 << IDX_W;
  // Upper bound on stream words sent over all tests
  localparam int TEST_WORDS     = 115;
  // Four cycles per word, plus both resets and drain gaps
  localparam int TIMEOUT_CYCLES = 4 * TEST_WORDS + 64;

  logic        clk;
  logic        rst = 1'b1;
  chdr_word_t  s_dma_tdata = '0;
  dma_id_t     s_dma_tuser = '0;
  logic        s_dma_tlast = 1'b0;
  logic        s_dma_tvalid = 1'b0;
  logic        s_dma_tready;
  chdr_word_t  m_dma_tdata;
  dma_id_t     m_dma_tuser;
  logic        m_dma_tlast;
  logic        m_dma_tvalid;
  logic        m_dma_tready = 1'b1;
  chdr_word_t  s_chdr_tdata = '0;
  logic        s_chdr_tlast = 1'b0;
  logic        s_chdr_tvalid = 1'b0;
  logic        s_chdr_tready;
  chdr_word_t  m_chdr_tdata;
  logic        m_chdr_tlast;
  logic        m_chdr_tvalid;
  logic        m_chdr_tready = 1'b1;
  logic [15:0] drop_count;

  // Route table model, indexed by the low EPID bits
  logic        mdl_valid [TBL_DEPTH];
  dma_id_t     mdl_id [TBL_DEPTH];
  int          exp_drops = 0;
  logic [64:0] exp_chdr [$];   // {tlast, tdata}
  logic [72:0] exp_dma [$];    // {tuser, tlast, tdata}

  logic [31:0] rng_state = 32'h5603;
  logic [31:0] ready_bits;
  logic        rand_ready = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycles = 0;
  int          assert_fails;

  tb_clk_gen i_clk_gen (
    .clk (clk)
  );

  liberio_chdr64_adapter i_liberio_chdr64_adapter (.*);

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Header: type in 55..53, EPID in 15..0, random filler between
  function automatic chdr_word_t make_hdr(input chdr_pkt_type_t t, input epid_t epid);
    return {8'h00, t, 5'd0, xorshift32(), epid};
  endfunction

  task automatic check(input string what, input logic [72:0] got, input logic [72:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called at a falling edge, returns at the falling edge after the handshake
  task automatic dma_word(input chdr_word_t d, input dma_id_t u, input logic l);
    s_dma_tdata  = d;
    s_dma_tuser  = u;
    s_dma_tlast  = l;
    s_dma_tvalid = 1'b1;
    @(posedge clk);
    while (!s_dma_tready) @(posedge clk);
    @(negedge clk);
    s_dma_tvalid = 1'b0;
  endtask

  task automatic chdr_word(input chdr_word_t d, input logic l);
    s_chdr_tdata  = d;
    s_chdr_tlast  = l;
    s_chdr_tvalid = 1'b1;
    @(posedge clk);
    while (!s_chdr_tready) @(posedge clk);
    @(negedge clk);
    s_chdr_tvalid = 1'b0;
  endtask

  // Ordinary packet, expected unchanged on m_chdr
  task automatic send_dma_pkt(input chdr_pkt_type_t t, input epid_t epid, input int len,
                              input dma_id_t user);
    chdr_word_t w;
    int         i;
    for (i = 0; i < len; i++) begin
      w = (i == 0) ? make_hdr(t, epid) : {xorshift32(), xorshift32()};
      exp_chdr.push_back({i == len - 1, w});
      dma_word(w, user, i == len - 1);
    end
  endtask

  // Management header to EPID 0, second word names the source EPID
  task automatic send_adv(input epid_t epid, input dma_id_t id);
    mdl_valid[epid[IDX_W-1:0]] = 1'b1;
    mdl_id[epid[IDX_W-1:0]]    = id;
    dma_word(make_hdr(PKT_MGMT, 16'h0000), id, 1'b0);
    dma_word({xorshift32(), 16'h0000, epid}, id, 1'b1);
  endtask

  // Route is decided by the header, optionally rewritten after it
  task automatic send_chdr_pkt(input epid_t epid, input int len, input logic mid_adv,
                               input dma_id_t new_id);
    logic       hit;
    dma_id_t    id;
    chdr_word_t w;
    int         i;
    hit = mdl_valid[epid[IDX_W-1:0]];
    id  = mdl_id[epid[IDX_W-1:0]];
    if (!hit) begin
      exp_drops++;
    end
    for (i = 0; i < len; i++) begin
      w = (i == 0) ? make_hdr(PKT_DATA, epid) : {xorshift32(), xorshift32()};
      if (hit) begin
        exp_dma.push_back({id, i == len - 1, w});
      end
      chdr_word(w, i == len - 1);
      if (i == 0 && mid_adv) begin
        send_adv(epid, new_id);
      end
    end
  endtask

  task automatic reset_dut();
    int i;
    rst = 1'b1;
    for (i = 0; i < TBL_DEPTH; i++) begin
      mdl_valid[i] = 1'b0;
    end
    exp_drops = 0;
    // Sixteen rising edges in reset, released on a falling edge
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // Drain both outputs, then compare the drop counter
  task automatic end_test(input string name, input int err_before);
    while (exp_chdr.size() != 0 || exp_dma.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    check("drop_count", drop_count, exp_drops);
    tests++;
    $display("test %-16s %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_dma_forward();
    int e;
    e = errors;
    send_dma_pkt(PKT_DATA, 16'h0012, 1, 8'h01);
    send_dma_pkt(PKT_CTRL, 16'h0034, 2, 8'hff);
    send_dma_pkt(PKT_DATA_TS, 16'h0056, 3, 8'h00);
    // Management packet to a nonzero EPID is forwarded
    send_dma_pkt(PKT_MGMT, 16'h0078, 4, 8'h5a);
    end_test("dma_forward", e);
  endtask

  task automatic test_advertise();
    int e;
    e = errors;
    send_adv(16'h0003, 8'ha3);
    send_adv(16'h0005, 8'hb5);
    send_dma_pkt(PKT_DATA, 16'h0003, 2, 8'h11);
    send_chdr_pkt(16'h0003, 3, 1'b0, '0);
    send_chdr_pkt(16'h0005, 3, 1'b0, '0);
    end_test("advertise", e);
  endtask

  task automatic test_rewrite_in_flight();
    int e;
    e = errors;
    send_adv(16'h0007, 8'h71);
    send_chdr_pkt(16'h0007, 5, 1'b1, 8'h72);
    // Next packet picks up the new ID
    send_chdr_pkt(16'h0007, 3, 1'b0, '0);
    end_test("rewrite_in_flight", e);
  endtask

  task automatic test_route_miss();
    int e;
    e = errors;
    send_chdr_pkt(16'h0009, 2, 1'b0, '0);
    send_chdr_pkt(16'h0003, 2, 1'b0, '0);
    send_chdr_pkt(16'h000a, 3, 1'b0, '0);
    send_chdr_pkt(16'h000b, 4, 1'b0, '0);
    end_test("route_miss", e);
  endtask

  task automatic test_random_traffic();
    int e;
    int a;
    int b;
    e = errors;
    rand_ready = 1'b1;
    fork
      for (a = 0; a < 8; a++) begin
        send_dma_pkt(PKT_DATA, 16'h0100 + a, 1 + (xorshift32() % 4), dma_id_t'(a));
      end
      // EPIDs 3, 5, 7 hit and 9 misses
      for (b = 0; b < 8; b++) begin
        send_chdr_pkt(epid_t'(3 + 2 * (xorshift32() % 4)), 1 + (xorshift32() % 4), 1'b0, '0);
      end
    join
    rand_ready = 1'b0;
    end_test("random_traffic", e);
  endtask

  task automatic test_second_reset();
    int e;
    e = errors;
    reset_dut();
    check("drop_count after reset", drop_count, 0);
    send_chdr_pkt(16'h0003, 3, 1'b0, '0);
    send_chdr_pkt(16'h0005, 3, 1'b0, '0);
    end_test("second_reset", e);
  endtask

  // ----------------------------------------------------------------------
  // Ready generation, output monitors, timeout
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    ready_bits = rand_ready ? xorshift32() : 32'hffff_ffff;
    m_chdr_tready = ready_bits[0];
    m_dma_tready  = ready_bits[8];
  end

  always @(posedge clk) begin
    if (!rst && m_chdr_tvalid && m_chdr_tready) begin
      if (exp_chdr.size() == 0) begin
        $display("unexpected word %h on m_chdr at %0t", m_chdr_tdata, $time);
        errors++;
      end else begin
        check("m_chdr word", {m_chdr_tlast, m_chdr_tdata}, exp_chdr.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && m_dma_tvalid && m_dma_tready) begin
      if (exp_dma.size() == 0) begin
        $display("unexpected word %h on m_dma at %0t", m_dma_tdata, $time);
        errors++;
      end else begin
        check("m_dma word", {m_dma_tuser, m_dma_tlast, m_dma_tdata}, exp_dma.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    reset_dut();
    test_dma_forward();
    test_advertise();
    test_rewrite_in_flight();
    test_route_miss();
    test_random_traffic();
    test_second_reset();
    assert_fails = i_liberio_chdr64_adapter.i_props.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/chdr_pkg.sv
hw/xport_pkg.sv
hw/xport_route_table.sv
hw/xport_adapter_ctrl.sv
hw/xport_dma_ingress.sv
hw/xport_chdr_egress.sv
hw/liberio_chdr64_adapter.sv
dv/tb_clk_gen.sv
dv/xport_adapter_properties.sv
dv/tb_liberio_adapter.sv

// ==== Bender.yml ====
package:
  name: liberio_chdr64_adapter

sources:
  - include_dirs:
      - hw
    files:
      - hw/chdr_pkg.sv
      - hw/xport_pkg.sv
      - hw/xport_route_table.sv
      - hw/xport_adapter_ctrl.sv
      - hw/xport_dma_ingress.sv
      - hw/xport_chdr_egress.sv
      - hw/liberio_chdr64_adapter.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clk_gen.sv
      - dv/xport_adapter_properties.sv
      - dv/tb_liberio_adapter.sv
